// File: Makefile
# Verilator simulation of the time-tag receive path
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f tb.f --top-module link_tb -o link_tb
	./obj_dir/link_tb

clean:
	rm -rf obj_dir

// File: common/link_cfg.svh
// ==============================
// Build settings of the time-tag receive path
// FIFO depth must be a power of two
// Word width is fixed at 32 by the tag word format
// Timestamp is wrap count above fine time, 64 bits
// ==============================
`ifndef LINK_CFG_SVH
`define LINK_CFG_SVH

// Beat geometry, four 32-bit words per beat
`define LINK_WORD_BITS 32
`define LINK_WORDS 4

// Frame buffer depth in beats
`define LINK_FIFO_DEPTH 64

// Tag word fields
`define LINK_CH_BITS 5
`define LINK_FINE_BITS 26
`define LINK_TS_BITS 64

// Register map, byte-wide word addresses
`define LINK_REG_ADDR_BITS 8
`define LINK_ID_WORD 32'd1
`define LINK_ADDR_ID 8'h00
`define LINK_ADDR_DEPTH 8'h01
`define LINK_ADDR_DROPPED 8'h02
`define LINK_ADDR_GOOD 8'h03

`endif

// File: common/link_pkg.sv
// ==============================
// Shared types of the receive path
// Keep mask is contiguous from word 0
// crc_ok is meaningful on the last beat only
// ==============================
`include "link_cfg.svh"

package link_pkg;

    // One 128-bit beat with per-word keep
    typedef struct packed {
        logic [`LINK_WORDS*`LINK_WORD_BITS-1:0] data;
        logic [`LINK_WORDS-1:0]                 keep;
        logic                                   last;
        // Set by the checker on a passing last beat
        logic                                   crc_ok;
    } link_beat_t;

    // Event view of a tag word, kind bit clear
    typedef struct packed {
        logic                       kind;
        logic [`LINK_CH_BITS-1:0]   channel;
        logic [`LINK_FINE_BITS-1:0] fine;
    } tag_evt_fields_t;

    // Wrap marker view, kind bit set
    typedef struct packed {
        logic                       kind;
        logic [`LINK_WORD_BITS-2:0] unused;
    } tag_wrap_fields_t;

    // Same 32-bit word, read either way
    typedef union packed {
        tag_evt_fields_t  evt;
        tag_wrap_fields_t wrap;
    } tag_word_t;

    // Decoded output event
    typedef struct packed {
        logic [`LINK_CH_BITS-1:0] channel;
        logic [`LINK_TS_BITS-1:0] timestamp;
    } tag_event_t;

    // Host register request, Wishbone style
    typedef struct packed {
        logic                           cyc;
        logic                           stb;
        logic                           we;
        logic [`LINK_REG_ADDR_BITS-1:0] adr;
    } reg_req_t;

endpackage

// File: fcs_check/fcs_checker.sv
// ==============================
// Ethernet CRC-32 check per frame
// Input cannot stall, one cycle latency
// Last valid word of a frame is the FCS
// Frame must hold at least two words
// ==============================
`include "link_cfg.svh"

module fcs_checker import link_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_clk_rst,
    input  link_beat_t in_beat_i,
    input  logic       in_valid_i,
    output link_beat_t out_beat_o,
    output logic       out_valid_o
);

    localparam int          WB       = `LINK_WORD_BITS;
    // Reflected polynomial, LSB first
    localparam logic [31:0] CRC_POLY = 32'hEDB88320;
    localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;

    logic [31:0]            crc_q;
    logic [31:0]            crc_next;
    logic [31:0]            fcs_word;
    logic [`LINK_WORDS-1:0] fcs_lane;
    logic [`LINK_WORDS-1:0] keep_up;

    // Fold one word, bit 0 first, which is byte 7:0 first
    function automatic logic [31:0] crc_fold(input logic [31:0] crc, input logic [31:0] word);
        logic [31:0] c;
        c = crc ^ word;
        for (int b = 0; b < 32; b++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    // Walk the lanes in order
    always_comb begin
        // Highest valid lane has no valid neighbour above
        keep_up  = in_beat_i.keep >> 1;
        fcs_lane = '0;
        fcs_word = '0;
        crc_next = crc_q;
        for (int w = 0; w < `LINK_WORDS; w++) begin
            if (in_beat_i.keep[w]) begin
                if (in_beat_i.last && !keep_up[w]) begin
                    // Check sequence word is held aside
                    fcs_lane[w] = 1'b1;
                    fcs_word    = in_beat_i.data[w*WB +: WB];
                end else begin
                    crc_next = crc_fold(crc_next, in_beat_i.data[w*WB +: WB]);
                end
            end
        end
    end

    // Running CRC and output strobe
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            crc_q       <= CRC_INIT;
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= in_valid_i;
            if (in_valid_i) begin
                // Reseed after the frame's last beat
                crc_q <= in_beat_i.last ? CRC_INIT : crc_next;
            end
        end
    end

    // Output beat, FCS lane removed
    always_ff @(posedge sys_clk) begin
        if (in_valid_i) begin
            out_beat_o.data   <= in_beat_i.data;
            out_beat_o.keep   <= in_beat_i.keep & ~fcs_lane;
            out_beat_o.last   <= in_beat_i.last;
            // Final inversion before compare
            out_beat_o.crc_ok <= in_beat_i.last && (~crc_next == fcs_word);
        end
    end

    // Keep mask must start at word 0 with no holes
    a_keep_contig: assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
        in_valid_i |-> (in_beat_i.keep != '0) &&
                       ((in_beat_i.keep & (in_beat_i.keep + 1'b1)) == '0));

endmodule

// File: frame_fifo/frame_fifo.sv
// ==============================
// Frame buffer with commit and rewind
// Only whole good frames become readable
// Full or bad frames are dropped whole
// Read data comes straight from the array
// ==============================
`include "link_cfg.svh"

module frame_fifo import link_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_clk_rst,
    input  link_beat_t in_beat_i,
    input  logic       in_valid_i,
    output link_beat_t out_beat_o,
    output logic       out_valid_o,
    input  logic       out_ready_i,
    output logic       good_frame_o,
    output logic       dropped_frame_o
);

    localparam int            DEPTH    = `LINK_FIFO_DEPTH;
    localparam int            AW       = $clog2(DEPTH);
    // Pointers carry one extra bit to tell full from empty
    localparam logic [AW:0]   FULL_CNT = (AW+1)'(DEPTH);

    link_beat_t  mem [DEPTH];
    logic [AW:0] wr_ptr_q;
    logic [AW:0] commit_ptr_q;
    logic [AW:0] rd_ptr_q;
    logic        drop_q;
    logic        full;
    logic        wr_en;
    logic        frame_bad;

    // Uncommitted writes also count toward full
    assign full  = (wr_ptr_q - rd_ptr_q) == FULL_CNT;
    // Once a frame overflowed, its later beats are not stored
    assign wr_en = in_valid_i && !full && !drop_q;

    // Rewind on CRC failure, earlier overflow, or no room for the last beat
    assign frame_bad = !in_beat_i.crc_ok || drop_q || full;

    // Reader sees committed beats only
    assign out_valid_o = rd_ptr_q != commit_ptr_q;
    assign out_beat_o  = mem[rd_ptr_q[AW-1:0]];

    // Beat storage
    always_ff @(posedge sys_clk) begin
        if (wr_en) begin
            mem[wr_ptr_q[AW-1:0]] <= in_beat_i;
        end
    end

    // Pointers, drop mark and frame pulses
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            wr_ptr_q        <= '0;
            commit_ptr_q    <= '0;
            rd_ptr_q        <= '0;
            drop_q          <= 1'b0;
            good_frame_o    <= 1'b0;
            dropped_frame_o <= 1'b0;
        end else begin
            good_frame_o    <= 1'b0;
            dropped_frame_o <= 1'b0;
            if (out_valid_o && out_ready_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (in_valid_i) begin
                if (in_beat_i.last) begin
                    drop_q <= 1'b0;
                    if (frame_bad) begin
                        // Back to the last commit
                        wr_ptr_q        <= commit_ptr_q;
                        dropped_frame_o <= 1'b1;
                    end else begin
                        // Last beat written and committed at the same edge
                        wr_ptr_q        <= wr_ptr_q + 1'b1;
                        commit_ptr_q    <= wr_ptr_q + 1'b1;
                        good_frame_o    <= 1'b1;
                    end
                end else if (wr_en) begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end else begin
                    // No room mid-frame, mark for drop at last
                    drop_q <= 1'b1;
                end
            end
        end
    end

    // Committed beats never outnumber storage
    a_commit_depth: assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
        (commit_ptr_q - rd_ptr_q) <= FULL_CNT);

    // Stalled output holds its beat
    a_out_stable: assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_beat_o));

endmodule

// File: logic/link_regs.sv
// ==============================
// Read-only status registers
// Ack is a one-cycle pulse after the request
// Writes are acked and have no effect
// ==============================
`include "link_cfg.svh"

module link_regs import link_pkg::*; (
    input  logic                       sys_clk,
    input  logic                       sys_clk_rst,
    input  reg_req_t                   req_i,
    input  logic [`LINK_WORD_BITS-1:0] wr_data_i,
    output logic                       ack_o,
    output logic [`LINK_WORD_BITS-1:0] rd_data_o,
    input  logic                       good_frame_i,
    input  logic                       dropped_frame_i
);

    logic [31:0] good_cnt_q;
    logic [31:0] drop_cnt_q;
    logic        req_hit;

    // Held request does not re-trigger while ack is high
    assign req_hit = req_i.cyc && req_i.stb && !ack_o;

    // Ack machine and frame counters
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            ack_o      <= 1'b0;
            good_cnt_q <= '0;
            drop_cnt_q <= '0;
        end else begin
            ack_o <= req_hit;
            // Counters stick at all ones
            if (good_frame_i && good_cnt_q != '1) begin
                good_cnt_q <= good_cnt_q + 1'b1;
            end
            if (dropped_frame_i && drop_cnt_q != '1) begin
                drop_cnt_q <= drop_cnt_q + 1'b1;
            end
        end
    end

    // Read decode
    always_ff @(posedge sys_clk) begin
        if (req_hit && !req_i.we) begin
            case (req_i.adr)
                `LINK_ADDR_ID:      rd_data_o <= `LINK_ID_WORD;
                `LINK_ADDR_DEPTH:   rd_data_o <= 32'(`LINK_FIFO_DEPTH);
                `LINK_ADDR_DROPPED: rd_data_o <= drop_cnt_q;
                `LINK_ADDR_GOOD:    rd_data_o <= good_cnt_q;
                default:            rd_data_o <= '0;
            endcase
        end
    end

    // Host must present known data on a write
    a_wr_known: assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
        req_i.cyc && req_i.stb && req_i.we |-> !$isunknown(wr_data_i));

endmodule

// File: logic/link_top.sv
// ==============================
// Receive path top level
// Line input has no ready, frames drop when full
// Frame end to first event is not fixed
// ==============================
`include "link_cfg.svh"

module link_top import link_pkg::*; (
    input  logic                       sys_clk,
    input  logic                       sys_clk_rst,
    input  link_beat_t                 rx_beat_i,
    input  logic                       rx_valid_i,
    output tag_event_t                 ev_o,
    output logic                       ev_valid_o,
    input  logic                       ev_ready_i,
    input  reg_req_t                   req_i,
    input  logic [`LINK_WORD_BITS-1:0] wr_data_i,
    output logic                       ack_o,
    output logic [`LINK_WORD_BITS-1:0] rd_data_o
);

    // Checker to buffer
    link_beat_t chk_beat;
    logic       chk_valid;
    // Buffer to decoder
    link_beat_t buf_beat;
    logic       buf_valid;
    logic       buf_ready;
    // Frame pulses to registers
    logic       good_pulse;
    logic       drop_pulse;

    // CRC check, marks the last beat
    fcs_checker u_fcs_checker (
        .sys_clk     (sys_clk),
        .sys_clk_rst (sys_clk_rst),
        .in_beat_i   (rx_beat_i),
        .in_valid_i  (rx_valid_i),
        .out_beat_o  (chk_beat),
        .out_valid_o (chk_valid)
    );

    frame_fifo u_frame_fifo (
        .sys_clk         (sys_clk),
        .sys_clk_rst     (sys_clk_rst),
        .in_beat_i       (chk_beat),
        .in_valid_i      (chk_valid),
        .out_beat_o      (buf_beat),
        .out_valid_o     (buf_valid),
        .out_ready_i     (buf_ready),
        .good_frame_o    (good_pulse),
        .dropped_frame_o (drop_pulse)
    );

    tag_decoder u_tag_decoder (
        .sys_clk     (sys_clk),
        .sys_clk_rst (sys_clk_rst),
        .in_beat_i   (buf_beat),
        .in_valid_i  (buf_valid),
        .in_ready_o  (buf_ready),
        .ev_o        (ev_o),
        .ev_valid_o  (ev_valid_o),
        .ev_ready_i  (ev_ready_i)
    );

    // Host-visible status
    link_regs u_link_regs (
        .sys_clk         (sys_clk),
        .sys_clk_rst     (sys_clk_rst),
        .req_i           (req_i),
        .wr_data_i       (wr_data_i),
        .ack_o           (ack_o),
        .rd_data_o       (rd_data_o),
        .good_frame_i    (good_pulse),
        .dropped_frame_i (drop_pulse)
    );

endmodule

// File: logic/tag_decoder.sv
// ==============================
// Tag word decoder, one lane per cycle
// First beat of a frame is the header
// Header word 1 seeds the wrap count
// ==============================
`include "link_cfg.svh"

module tag_decoder import link_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_clk_rst,
    input  link_beat_t in_beat_i,
    input  logic       in_valid_i,
    output logic       in_ready_o,
    output tag_event_t ev_o,
    output logic       ev_valid_o,
    input  logic       ev_ready_i
);

    localparam int            WB        = `LINK_WORD_BITS;
    localparam int            WRAP_BITS = `LINK_TS_BITS - `LINK_FINE_BITS;
    localparam int            LW        = $clog2(`LINK_WORDS);
    localparam logic [LW-1:0] LAST_LANE = LW'(`LINK_WORDS - 1);

    logic                 header_q;
    logic [LW-1:0]        lane_q;
    logic [WRAP_BITS-1:0] wrap_q;
    tag_word_t            cur;
    logic                 lane_on;
    logic                 is_wrap;
    logic                 slot_free;
    logic                 lane_done;
    logic                 step;
    logic                 emit;

    // Current lane seen through the union
    assign cur     = in_beat_i.data[lane_q*WB +: WB];
    assign lane_on = in_beat_i.keep[lane_q];
    assign is_wrap = cur.wrap.kind;

    // Output register free now or freed this cycle
    assign slot_free = !ev_valid_o || ev_ready_i;
    // Empty lanes and markers never wait on the output
    assign lane_done = !lane_on || is_wrap || slot_free;
    assign step      = in_valid_i && !header_q && lane_done;
    assign emit      = step && lane_on && !is_wrap;

    // Beat is taken whole: header at once, body after its last lane
    assign in_ready_o = header_q || (lane_done && lane_q == LAST_LANE);

    // Frame position and wrap count
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            header_q   <= 1'b1;
            lane_q     <= '0;
            wrap_q     <= '0;
            ev_valid_o <= 1'b0;
        end else begin
            if (in_valid_i && header_q) begin
                // Zero-extended seed, other header words ignored
                wrap_q   <= WRAP_BITS'(in_beat_i.data[2*WB-1:WB]);
                header_q <= in_beat_i.last;
            end else if (step) begin
                if (lane_on && is_wrap) begin
                    wrap_q <= wrap_q + 1'b1;
                end
                if (lane_q == LAST_LANE) begin
                    lane_q   <= '0;
                    header_q <= in_beat_i.last;
                end else begin
                    lane_q <= lane_q + 1'b1;
                end
            end
            if (emit) begin
                ev_valid_o <= 1'b1;
            end else if (ev_ready_i) begin
                ev_valid_o <= 1'b0;
            end
        end
    end

    // Timestamp is wrap count above fine time
    always_ff @(posedge sys_clk) begin
        if (emit) begin
            ev_o.channel   <= cur.evt.channel;
            ev_o.timestamp <= {wrap_q, cur.evt.fine};
        end
    end

    // Back-pressure holds the pending event
    a_ev_stable: assert property (@(posedge sys_clk) disable iff (sys_clk_rst)
        ev_valid_o && !ev_ready_i |=> ev_valid_o && $stable(ev_o));

endmodule

// File: tb.f
+incdir+common
common/link_pkg.sv
fcs_check/fcs_checker.sv
frame_fifo/frame_fifo.sv
logic/tag_decoder.sv
logic/link_regs.sv
logic/link_top.sv
verification/link_tb.sv

// File: verification/link_tb.sv
// ==============================
// Self-checking testbench for link_top
// Expected events come from a frame model
// Stops at the first mismatch or timeout
// ==============================
module link_tb import link_pkg::*; ();

    // Body pattern of the wrap frame, bit set means marker
    localparam logic [8:0] WRAP_PAT = 9'h04E;

    logic        sys_clk;
    logic        sys_clk_rst;
    link_beat_t  rx_beat_i;
    logic        rx_valid_i;
    tag_event_t  ev_o;
    logic        ev_valid_o;
    logic        ev_ready_i = 1'b0;
    reg_req_t    req_i;
    logic [31:0] wr_data_i;
    logic        ack_o;
    logic [31:0] rd_data_o;

    integer      seed = 32;
    // 0 always ready, 1 random, 2 held low
    int          ready_mode;
    int          exp_good;
    int          exp_dropped;
    logic [31:0] frame_words[$];
    tag_event_t  exp_q[$];
    tag_event_t  exp_ev;
    logic [31:0] rd;

    link_top dut (.*);

    initial begin
        sys_clk = 1'b0;
        forever begin
            #50 sys_clk = ~sys_clk;
        end
    end

    task automatic stop_with_failure();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] expv);
        if (got !== expv) begin
            $display("Error: %s got %h expected %h", name, got, expv);
            stop_with_failure();
        end
    endtask

    // Random tag word, marker with odds wrap_in_128 out of 128
    function automatic logic [31:0] rand_tag(input int wrap_in_128);
        logic [31:0] r;
        int          pick;
        r     = $random(seed);
        pick  = $random(seed) & 127;
        r[31] = (pick < wrap_in_128);
        return r;
    endfunction

    // Reference CRC-32, reflected, byte 7:0 of each word first
    function automatic logic [31:0] frame_crc();
        logic [31:0] crc;
        crc = 32'hFFFF_FFFF;
        for (int i = 0; i < frame_words.size(); i++) begin
            for (int b = 0; b < 4; b++) begin
                crc = crc ^ {24'd0, frame_words[i][8*b +: 8]};
                for (int k = 0; k < 8; k++) begin
                    crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
                end
            end
        end
        return ~crc;
    endfunction

    // Header beat, word 1 is the wrap seed
    task automatic build_frame(input int n_body, input int wrap_in_128);
        frame_words.delete();
        for (int i = 0; i < 4; i++) begin
            frame_words.push_back($random(seed));
        end
        for (int i = 0; i < n_body; i++) begin
            frame_words.push_back(rand_tag(wrap_in_128));
        end
    endtask

    // Expected events of header plus body, FCS not yet appended
    task automatic model_events();
        logic [37:0] wrap;
        tag_event_t  ev;
        wrap = 38'(frame_words[1]);
        for (int i = 4; i < frame_words.size(); i++) begin
            if (frame_words[i][31]) begin
                wrap = wrap + 38'd1;
            end else begin
                ev.channel   = frame_words[i][30:26];
                ev.timestamp = 64'(wrap) * 64'h400_0000 + 64'(frame_words[i][25:0]);
                exp_q.push_back(ev);
            end
        end
    endtask

    // Four words per beat, keep from word 0, last on the final beat
    task automatic send_frame();
        link_beat_t beat;
        int         n;
        n = frame_words.size();
        for (int base = 0; base < n; base += 4) begin
            beat = '0;
            for (int w = 0; w < 4; w++) begin
                if (base + w < n) begin
                    beat.data[32*w +: 32] = frame_words[base + w];
                    beat.keep[w]          = 1'b1;
                end
            end
            beat.last = (base + 4 >= n);
            @(posedge sys_clk);
            rx_beat_i  <= beat;
            rx_valid_i <= 1'b1;
        end
        @(posedge sys_clk);
        rx_valid_i <= 1'b0;
    endtask

    task automatic finish_frame(input bit expect_good, input bit corrupt);
        logic [31:0] fcs;
        fcs = frame_crc();
        if (expect_good) begin
            model_events();
            exp_good++;
        end else begin
            exp_dropped++;
        end
        frame_words.push_back(corrupt ? ~fcs : fcs);
        send_frame();
    endtask

    // One bus cycle, ack expected exactly one cycle after the request
    task automatic reg_access(input bit we, input logic [7:0] adr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        reg_req_t req;
        int       n;
        req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr};
        n   = 0;
        @(posedge sys_clk);
        req_i     <= req;
        wr_data_i <= wdata;
        @(negedge sys_clk);
        while (!ack_o) begin
            n++;
            if (n > 16) begin
                $display("Timed out waiting for the register ack");
                stop_with_failure();
            end
            @(negedge sys_clk);
        end
        check("ack_o delay", 64'(n), 64'd1);
        rdata = rd_data_o;
        @(posedge sys_clk);
        req_i <= '0;
        @(negedge sys_clk);
        check("ack_o", 64'(ack_o), 64'd0);
    endtask

    task automatic expect_reg(input logic [7:0] adr, input int expv);
        logic [31:0] val;
        reg_access(1'b0, adr, 32'd0, val);
        check("rd_data_o", 64'(val), 64'(expv));
    endtask

    // Counters settle a few cycles after the frame ends
    task automatic poll_reg(input logic [7:0] adr, input int expv);
        logic [31:0] val;
        int          tries;
        tries = 0;
        reg_access(1'b0, adr, 32'd0, val);
        while (val != 32'(expv) && tries < 40) begin
            tries++;
            reg_access(1'b0, adr, 32'd0, val);
        end
        check("rd_data_o", 64'(val), 64'(expv));
    endtask

    task automatic drain_events(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge sys_clk);
            n++;
            if (n > limit) begin
                $display("Timed out waiting for the expected events");
                stop_with_failure();
            end
        end
    endtask

    // Output back-pressure
    always @(posedge sys_clk) begin
        if (ready_mode == 0) begin
            ev_ready_i <= 1'b1;
        end else if (ready_mode == 1) begin
            ev_ready_i <= ($random(seed) & 1) != 0;
        end else begin
            ev_ready_i <= 1'b0;
        end
    end

    // Each accepted event against the head of the model queue
    always @(posedge sys_clk) begin
        if (!sys_clk_rst && ev_valid_o && ev_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("An event arrived when none was expected");
                stop_with_failure();
            end else begin
                exp_ev = exp_q.pop_front();
                check("ev_o.channel", 64'(ev_o.channel), 64'(exp_ev.channel));
                check("ev_o.timestamp", ev_o.timestamp, exp_ev.timestamp);
            end
        end
    end

    initial begin
        sys_clk_rst = 1'b1;
        rx_beat_i   = '0;
        rx_valid_i  = 1'b0;
        req_i       = '0;
        wr_data_i   = '0;
        ready_mode  = 0;
        exp_good    = 0;
        exp_dropped = 0;
        repeat (5) @(posedge sys_clk);
        sys_clk_rst <= 1'b0;
        @(negedge sys_clk);
        check("ev_valid_o", 64'(ev_valid_o), 64'd0);
        check("ack_o", 64'(ack_o), 64'd0);
        // Register map, unmapped reads follow nonzero ones
        expect_reg(8'h00, 1);
        expect_reg(8'h07, 0);
        expect_reg(8'h01, 64);
        expect_reg(8'hff, 0);
        expect_reg(8'h02, 0);
        expect_reg(8'h03, 0);
        // A write that must not stick
        reg_access(1'b1, 8'h03, 32'hDEAD_BEEF, rd);
        expect_reg(8'h03, 0);
        // Event-only frames of growing length
        for (int f = 0; f < 4; f++) begin
            build_frame(3 + f * 3, 0);
            finish_frame(1'b1, 1'b0);
        end
        drain_events(2000);
        // Markers at lane 3 carry into the next beat
        build_frame(0, 0);
        for (int i = 0; i < 9; i++) begin
            frame_words.push_back(rand_tag(WRAP_PAT[i] ? 128 : 0));
        end
        finish_frame(1'b1, 1'b0);
        build_frame(14, 32);
        finish_frame(1'b1, 1'b0);
        drain_events(2000);
        poll_reg(8'h03, exp_good);
        // Bad check sequence, no events and one more drop
        build_frame(6, 16);
        finish_frame(1'b0, 1'b1);
        poll_reg(8'h02, exp_dropped);
        expect_reg(8'h03, exp_good);
        // Random back-pressure
        ready_mode = 1;
        for (int f = 0; f < 6; f++) begin
            build_frame(5 + f * 2, 24);
            finish_frame(1'b1, 1'b0);
        end
        drain_events(4000);
        // Output stalled, decoder holds only the first header beat
        // 16 frames of 4 beats fit, the rest drop whole
        ready_mode = 2;
        for (int f = 0; f < 18; f++) begin
            build_frame(11, 0);
            finish_frame(f < 16, 1'b0);
        end
        poll_reg(8'h02, exp_dropped);
        expect_reg(8'h03, exp_good);
        ready_mode = 1;
        drain_events(8000);
        expect_reg(8'h02, exp_dropped);
        expect_reg(8'h03, exp_good);
        // All expected events taken, so nothing may still wait at the output
        if (ev_valid_o !== 1'b0) begin
            $display("An unexpected event is still pending after the last frame");
            stop_with_failure();
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule
